/* verilog/riscvDefines.svh */
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

`define XLEN      32
`define PC_BITS   12
`define RESET_PC  12'd0

// Base opcodes
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OPIMM   7'b0010011
`define OPC_OP      7'b0110011

// addi x0, x0, 0
`define NOP_INSTR   32'h0000_0013

// Branch compare codes
`define F3_BEQ   3'b000
`define F3_BNE   3'b001
`define F3_BLT   3'b100
`define F3_BGE   3'b101
`define F3_BLTU  3'b110
`define F3_BGEU  3'b111

// Load width codes, stores share the low two bits
`define F3_LB    3'b000
`define F3_LH    3'b001
`define F3_LW    3'b010
`define F3_LBU   3'b100
`define F3_LHU   3'b101

`endif

/* verilog/riscvPkg.sv */
`include "riscvDefines.svh"

package riscvPkg;

   typedef logic [`XLEN-1:0] word_t;
   typedef logic [`PC_BITS-1:0] pc_t;
   typedef logic [4:0] regAddr_t;
   typedef logic [3:0] byteMask_t;

   // ALU operations
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_PASSB
   } aluOp_t;

   // Writeback source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_LOAD,
      WB_LINK
   } wbSel_t;

   // Operand source in execute
   typedef enum logic {
      FWD_REG,
      FWD_WB
   } fwdSel_t;

endpackage

/* verilog/dataMemIf.sv */
`timescale 1ns/100ps

interface dataMemIf import riscvPkg::*; ();

   // Request from execute
   word_t     addr;
   word_t     wdata;
   logic [2:0] funct3;
   logic      readEn;
   logic      writeEn;

   // Lane-placed store and returned load
   byteMask_t lsuMask;
   word_t     lsuWdata;
   word_t     rdata;
   word_t     loadData;

   modport pipe (
      output addr, wdata, funct3, readEn, writeEn,
      input  loadData
   );

   modport lsu (
      input  addr, wdata, funct3, readEn, writeEn, rdata,
      output lsuMask, lsuWdata, loadData
   );

endinterface

/* verilog/regFile.sv */
`timescale 1ns/100ps

module regFile import riscvPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  regAddr_t ra1,
   input  regAddr_t ra2,
   input  regAddr_t wa,
   input  logic     we,
   input  word_t    wd,
   output word_t    rd1,
   output word_t    rd2
);

   word_t regs [32];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wa != '0) begin
         regs[wa] <= wd;
      end
   end

   // x0 is never written so it reads back zero
   assign rd1 = regs[ra1];
   assign rd2 = regs[ra2];

endmodule

/* verilog/alu.sv */
`timescale 1ns/100ps

module alu import riscvPkg::*; (
   input  word_t  a,
   input  word_t  b,
   input  aluOp_t op,
   output word_t  result
);

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      case (op)
         ALU_ADD:   result = a + b;
         ALU_SUB:   result = a - b;
         ALU_SLL:   result = a << shamt;
         ALU_SLT:   result = word_t'($signed(a) < $signed(b));
         ALU_SLTU:  result = word_t'(a < b);
         ALU_XOR:   result = a ^ b;
         ALU_SRL:   result = a >> shamt;
         ALU_SRA:   result = $signed(a) >>> shamt;
         ALU_OR:    result = a | b;
         ALU_AND:   result = a & b;
         // LUI passes the immediate
         ALU_PASSB: result = b;
         default:   result = '0;
      endcase
   end

endmodule

/* verilog/decoder.sv */
`timescale 1ns/100ps
`include "riscvDefines.svh"

module decoder import riscvPkg::*; (
   input  word_t      instr,
   output regAddr_t   rs1,
   output regAddr_t   rs2,
   output regAddr_t   rd,
   output word_t      imm,
   output aluOp_t     aluOp,
   output logic       useImm,
   output logic       usePc,
   output logic       regWrite,
   output logic       isBranch,
   output logic       isJal,
   output logic       isJalr,
   output logic       memRead,
   output logic       memWrite,
   output wbSel_t     wbSel,
   output logic [2:0] funct3
);

   logic [6:0] opcode;
   logic       alt;
   logic       supported;
   word_t      immI, immS, immB, immU, immJ;

   // Shared by OP and OP-IMM
   // alt selects SUB or SRA
   function automatic aluOp_t opFromFunct3(input logic [2:0] f3, input logic altSel);
      case (f3)
         3'b000:  return altSel ? ALU_SUB : ALU_ADD;
         3'b001:  return ALU_SLL;
         3'b010:  return ALU_SLT;
         3'b011:  return ALU_SLTU;
         3'b100:  return ALU_XOR;
         3'b101:  return altSel ? ALU_SRA : ALU_SRL;
         3'b110:  return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   assign opcode = instr[6:0];
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign alt    = instr[30];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // Opcodes the core implements
   assign supported = opcode inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_BRANCH,
                                     `OPC_LOAD, `OPC_STORE, `OPC_OPIMM, `OPC_OP};

   always_comb begin
      // Defaults decode as a NOP
      imm       = immI;
      aluOp     = ALU_ADD;
      useImm    = 1'b0;
      usePc     = 1'b0;
      regWrite  = 1'b0;
      isBranch  = 1'b0;
      isJal     = 1'b0;
      isJalr    = 1'b0;
      memRead   = 1'b0;
      memWrite  = 1'b0;
      wbSel     = WB_ALU;
      case (opcode)
         `OPC_LUI: begin
            imm      = immU;
            aluOp    = ALU_PASSB;
            useImm   = 1'b1;
            regWrite = 1'b1;
         end
         `OPC_AUIPC: begin
            imm      = immU;
            usePc    = 1'b1;
            useImm   = 1'b1;
            regWrite = 1'b1;
         end
         // ALU forms the jump or branch target
         `OPC_JAL: begin
            imm      = immJ;
            usePc    = 1'b1;
            useImm   = 1'b1;
            isJal    = 1'b1;
            regWrite = 1'b1;
            wbSel    = WB_LINK;
         end
         `OPC_JALR: begin
            useImm   = 1'b1;
            isJalr   = 1'b1;
            regWrite = 1'b1;
            wbSel    = WB_LINK;
         end
         `OPC_BRANCH: begin
            imm      = immB;
            usePc    = 1'b1;
            useImm   = 1'b1;
            isBranch = 1'b1;
         end
         `OPC_LOAD: begin
            useImm   = 1'b1;
            memRead  = 1'b1;
            regWrite = 1'b1;
            wbSel    = WB_LOAD;
         end
         `OPC_STORE: begin
            imm      = immS;
            useImm   = 1'b1;
            memWrite = 1'b1;
         end
         `OPC_OPIMM: begin
            useImm   = 1'b1;
            regWrite = 1'b1;
            aluOp    = opFromFunct3(funct3, alt && funct3 == 3'b101);
         end
         `OPC_OP: begin
            regWrite = 1'b1;
            aluOp    = opFromFunct3(funct3, alt);
         end
         default: ;
      endcase
   end

   // Unknown opcodes must not touch architectural state
   always_comb begin
      if (!supported) begin
         assert (!regWrite && !memWrite)
            else $error("unsupported opcode %h writes state", opcode);
      end
   end

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit import riscvPkg::*; (
   input  regAddr_t rs1X,
   input  regAddr_t rs2X,
   input  regAddr_t rdW,
   input  logic     regWriteW,
   input  logic     redirect,
   output fwdSel_t  fwdA,
   output fwdSel_t  fwdB,
   output logic     squash
);

   logic wbLive;

   // Writeback holds a result bound for a real register
   assign wbLive = regWriteW && rdW != '0;

   always_comb begin
      fwdA = FWD_REG;
      fwdB = FWD_REG;
      if (wbLive && rdW == rs1X) begin
         fwdA = FWD_WB;
      end
      if (wbLive && rdW == rs2X) begin
         fwdB = FWD_WB;
      end
   end

   // Instruction fetched behind a redirect becomes a bubble
   assign squash = redirect;

endmodule

/* verilog/loadStoreUnit.sv */
`timescale 1ns/100ps
`include "riscvDefines.svh"

module loadStoreUnit import riscvPkg::*; (
   input logic clk,
   input logic rstN,
   input logic stall,
   dataMemIf.lsu mem
);

   logic [1:0] offset;
   logic [1:0] offsetQ;
   logic [2:0] funct3Q;
   byteMask_t  mask;
   word_t      shifted;

   assign offset = mem.addr[1:0];

   // Store lanes
   always_comb begin
      case (mem.funct3[1:0])
         2'b00:   mask = byteMask_t'(4'b0001 << offset);
         2'b01:   mask = byteMask_t'(4'b0011 << {offset[1], 1'b0});
         default: mask = 4'b1111;
      endcase
   end

   assign mem.lsuMask  = mem.writeEn ? mask : '0;
   assign mem.lsuWdata = mem.wdata << {offset, 3'b000};

   // Load format is needed one cycle after the request
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         offsetQ <= '0;
         funct3Q <= '0;
      end else if (!stall) begin
         offsetQ <= offset;
         funct3Q <= mem.funct3;
      end
   end

   assign shifted = mem.rdata >> {offsetQ, 3'b000};

   always_comb begin
      case (funct3Q)
         `F3_LB:  mem.loadData = {{24{shifted[7]}}, shifted[7:0]};
         `F3_LH:  mem.loadData = {{16{shifted[15]}}, shifted[15:0]};
         `F3_LBU: mem.loadData = {24'b0, shifted[7:0]};
         `F3_LHU: mem.loadData = {16'b0, shifted[15:0]};
         default: mem.loadData = shifted;
      endcase
   end

   assert property (@(posedge clk) disable iff (!rstN)
      (mem.readEn || mem.writeEn) && mem.funct3[1:0] == 2'b01 |-> !offset[0])
      else $error("misaligned halfword access at %h", mem.addr);

   assert property (@(posedge clk) disable iff (!rstN)
      (mem.readEn || mem.writeEn) && mem.funct3[1:0] == 2'b10 |-> offset == 2'b00)
      else $error("misaligned word access at %h", mem.addr);

endmodule

/* verilog/riscvPipeline.sv */
`timescale 1ns/100ps
`include "riscvDefines.svh"

module riscvPipeline import riscvPkg::*; (
   input  logic  clk,
   input  logic  rstN,
   input  logic  stall,
   output pc_t   icacheAddr,
   output logic  icacheRe,
   input  word_t instruction,
   dataMemIf.pipe mem
);

   pc_t        pc, pcX, target;
   logic       runQ, validX, advance, redirect, taken, squash;
   word_t      instrX, rd1, rd2, rs1Val, rs2Val, opA, opB, aluResult, wbValue;
   regAddr_t   rs1, rs2, rd;
   word_t      imm;
   aluOp_t     aluOp;
   logic       useImm, usePc, regWrite, isBranch, isJal, isJalr, memRead, memWrite;
   wbSel_t     wbSel;
   logic [2:0] funct3;
   fwdSel_t    fwdA, fwdB;

   // Writeback stage
   logic       regWriteW;
   regAddr_t   rdW;
   wbSel_t     wbSelW;
   word_t      aluW, linkW;

   // First fetch waits one cycle after reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         runQ <= 1'b0;
      end else begin
         runQ <= 1'b1;
      end
   end

   assign advance    = runQ && !stall;
   assign icacheAddr = pc;
   assign icacheRe   = advance;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc     <= `RESET_PC;
         pcX    <= `RESET_PC;
         validX <= 1'b0;
      end else if (advance) begin
         pc     <= redirect ? target : pc + pc_t'(4);
         pcX    <= pc;
         validX <= !squash;
      end
   end

   // Instruction memory answers one cycle after the fetch
   assign instrX = validX ? instruction : `NOP_INSTR;

   decoder u_decoder (
      .instr(instrX), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
      .useImm(useImm), .usePc(usePc), .regWrite(regWrite), .isBranch(isBranch),
      .isJal(isJal), .isJalr(isJalr), .memRead(memRead), .memWrite(memWrite),
      .wbSel(wbSel), .funct3(funct3)
   );

   regFile u_regFile (
      .clk(clk), .rstN(rstN), .ra1(rs1), .ra2(rs2), .wa(rdW), .we(regWriteW),
      .wd(wbValue), .rd1(rd1), .rd2(rd2)
   );

   hazardUnit u_hazardUnit (
      .rs1X(rs1), .rs2X(rs2), .rdW(rdW), .regWriteW(regWriteW), .redirect(redirect),
      .fwdA(fwdA), .fwdB(fwdB), .squash(squash)
   );

   // Operand selection
   assign rs1Val = (fwdA == FWD_WB) ? wbValue : rd1;
   assign rs2Val = (fwdB == FWD_WB) ? wbValue : rd2;
   assign opA    = usePc ? word_t'(pcX) : rs1Val;
   assign opB    = useImm ? imm : rs2Val;

   alu u_alu (.a(opA), .b(opB), .op(aluOp), .result(aluResult));

   always_comb begin
      case (funct3)
         `F3_BEQ:  taken = rs1Val == rs2Val;
         `F3_BNE:  taken = rs1Val != rs2Val;
         `F3_BLT:  taken = $signed(rs1Val) < $signed(rs2Val);
         `F3_BGE:  taken = $signed(rs1Val) >= $signed(rs2Val);
         `F3_BLTU: taken = rs1Val < rs2Val;
         `F3_BGEU: taken = rs1Val >= rs2Val;
         default:  taken = 1'b0;
      endcase
   end

   assign redirect = isJal || isJalr || (isBranch && taken);
   // JALR clears bit 0 of the sum
   assign target   = isJalr ? (aluResult[`PC_BITS-1:0] & ~pc_t'(1))
                            : aluResult[`PC_BITS-1:0];

   // Data memory request, held off while stalled
   assign mem.addr    = aluResult;
   assign mem.wdata   = rs2Val;
   assign mem.funct3  = funct3;
   assign mem.readEn  = memRead && advance;
   assign mem.writeEn = memWrite && advance;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         regWriteW <= 1'b0;
         rdW       <= '0;
         wbSelW    <= WB_ALU;
      end else if (advance) begin
         regWriteW <= regWrite;
         rdW       <= rd;
         wbSelW    <= wbSel;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         aluW  <= aluResult;
         linkW <= word_t'(pcX + pc_t'(4));
      end
   end

   always_comb begin
      case (wbSelW)
         WB_LOAD: wbValue = mem.loadData;
         WB_LINK: wbValue = linkW;
         default: wbValue = aluW;
      endcase
   end

   assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
      else $error("fetch address %h not word aligned", pc);

endmodule

/* verilog/riscvCore.sv */
`timescale 1ns/100ps

module riscvCore import riscvPkg::*; (
   input  logic      clk,
   input  logic      rstN,
   input  logic      stall,
   output pc_t       icacheAddr,
   output logic      icacheRe,
   input  word_t     instruction,
   output word_t     dcacheAddr,
   output byteMask_t dcacheWe,
   output logic      dcacheRe,
   output word_t     dcacheDin,
   input  word_t     dcacheDout
);

   dataMemIf memIf ();

   riscvPipeline u_pipeline (
      .clk(clk),
      .rstN(rstN),
      .stall(stall),
      .icacheAddr(icacheAddr),
      .icacheRe(icacheRe),
      .instruction(instruction),
      .mem(memIf.pipe)
   );

   loadStoreUnit u_loadStoreUnit (
      .clk(clk),
      .rstN(rstN),
      .stall(stall),
      .mem(memIf.lsu)
   );

   // Data memory port
   assign dcacheAddr  = memIf.addr;
   assign dcacheRe    = memIf.readEn;
   assign dcacheWe    = memIf.lsuMask;
   assign dcacheDin   = memIf.lsuWdata;
   assign memIf.rdata = dcacheDout;

endmodule

/* sim/riscvCoreTb.sv */
`timescale 1ns/100ps
`include "riscvDefines.svh"

module riscvCoreTb import riscvPkg::*; ();

   logic      clk, rstN, stall;
   pc_t       icacheAddr;
   logic      icacheRe, dcacheRe;
   word_t     instruction, dcacheAddr, dcacheDin, dcacheDout;
   byteMask_t dcacheWe;

   word_t     instrMem [1024];
   word_t     dataMem [1024];
   word_t     modelMem [1024];
   word_t     expAddr[$], expData[$];
   byteMask_t expMask[$];
   word_t     rngState, nextSlot, selfJump;
   int        pcW, storeIdx, waited;
   logic      stallOn;

   // Request sampled at the clock edge
   logic      icRe, dcRe;
   pc_t       icAddr;
   word_t     dcAddr, dcDin, rnd;
   byteMask_t dcWe;

   riscvCore u_dut (
      .clk(clk), .rstN(rstN), .stall(stall), .icacheAddr(icacheAddr), .icacheRe(icacheRe),
      .instruction(instruction), .dcacheAddr(dcacheAddr), .dcacheWe(dcacheWe),
      .dcacheRe(dcacheRe), .dcacheDin(dcacheDin), .dcacheDout(dcacheDout)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic word_t xorshift(input word_t s);
      word_t v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic word_t randWord();
      rngState = xorshift(rngState);
      return rngState;
   endfunction

   task automatic wrongValue(input string name, input word_t exp, input word_t got);
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic failNow(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1);
   endtask

   // Instruction encoders
   function automatic word_t encI(input logic [6:0] opc, input logic [2:0] f3,
                                  input word_t rd, input word_t rs1, input word_t imm);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
   endfunction

   function automatic word_t encR(input logic [6:0] f7, input logic [2:0] f3,
                                  input word_t rd, input word_t rs1, input word_t rs2);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
   endfunction

   function automatic word_t encS(input logic [2:0] f3, input word_t rs2, input word_t imm);
      return {imm[11:5], rs2[4:0], 5'd0, f3, imm[4:0], `OPC_STORE};
   endfunction

   function automatic word_t encB(input logic [2:0] f3, input word_t rs1, input word_t rs2,
                                  input word_t imm);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `OPC_BRANCH};
   endfunction

   function automatic word_t encU(input logic [6:0] opc, input word_t rd, input word_t imm);
      return {imm[19:0], rd[4:0], opc};
   endfunction

   function automatic word_t encJ(input word_t rd, input word_t imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OPC_JAL};
   endfunction

   task automatic emit(input word_t ins);
      instrMem[pcW] = ins;
      pcW++;
   endtask

   function automatic word_t pickReg();
      return 32'd1 + randWord() % 32'd31;
   endfunction

   // Store a register to a fresh word with a random width and lane
   task automatic storeReg(input word_t r);
      word_t sel, off;
      sel = randWord() % 32'd3;
      off = randWord();
      if (sel == 0) off = off & 32'd3;
      else if (sel == 1) off = off & 32'd2;
      else off = 0;
      emit(encS(sel[2:0], r, nextSlot + off));
      nextSlot = nextSlot + 32'd4;
   endtask

   task automatic buildProgram();
      logic [2:0] loadF3 [5];
      word_t kind, a, b, c, f3, imm;
      loadF3 = '{`F3_LB, `F3_LH, `F3_LW, `F3_LBU, `F3_LHU};
      for (int r = 1; r < 32; r++) begin
         emit(encU(`OPC_LUI, r, randWord()));
         emit(encI(`OPC_OPIMM, 3'd0, r, r, randWord()));
      end
      for (int g = 0; g < 60; g++) begin
         kind = randWord() % 32'd6;
         a = pickReg();
         b = pickReg();
         c = pickReg();
         f3 = randWord();
         case (kind)
            0: begin
               // Dependent OP then OP-IMM
               emit(encR({1'b0, f3[8] & (f3[2:0] == 3'd0 || f3[2:0] == 3'd5), 5'd0},
                         f3[2:0], a, b, c));
               imm = randWord();
               if (f3[5:4] == 2'd1) imm = imm & 32'h1f;
               else if (f3[5:4] == 2'd2) imm = (imm & 32'h41f);
               emit(encI(`OPC_OPIMM, f3[5:4] == 2'd1 ? 3'd1 :
                         f3[5:4] == 2'd2 ? 3'd5 : f3[2:0], b, a, imm));
               storeReg(b);
            end
            1: begin
               f3 = {29'd0, loadF3[randWord() % 32'd5]};
               imm = (randWord() % 32'd256) * 32'd4;
               if (f3[1:0] == 2'd0) imm = imm + (randWord() & 32'd3);
               else if (f3[1:0] == 2'd1) imm = imm + (randWord() & 32'd2);
               emit(encI(`OPC_LOAD, f3[2:0], a, 0, imm));
               emit(encI(`OPC_OPIMM, 3'd0, b, a, randWord()));
               storeReg(b);
               storeReg(a);
            end
            2: begin
               // A taken branch skips the store right behind it
               emit(encB(f3[2] ? f3[2:0] : {2'b00, f3[0]}, a, f3[7] ? a : b, 8));
               storeReg(c);
               storeReg(a);
            end
            3: begin
               emit(encJ(a, 8));
               storeReg(b);
               storeReg(a);
            end
            4: begin
               // Bit 0 of the JALR target is dropped
               emit(encU(`OPC_AUIPC, a, 0));
               emit(encI(`OPC_JALR, 3'd0, b, a, 17));
               storeReg(c);
               storeReg(c);
               storeReg(a);
               storeReg(b);
            end
            default: begin
               emit(encU(`OPC_LUI, a, randWord()));
               emit(encU(`OPC_AUIPC, b, randWord()));
               storeReg(a);
               storeReg(b);
            end
         endcase
      end
      emit(selfJump);
   endtask

   function automatic word_t aluCalc(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'd0, $signed(a) < $signed(b)};
         3'd3: return {31'd0, a < b};
         3'd4: return a ^ b;
         3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   // Architectural model that lists the stores in program order
   function automatic void runModel();
      word_t x [32];
      word_t pc, nextPc, ins, r1, r2, res, addr, w, immI, immS, immB, immJ, immU;
      logic [2:0] f3;
      logic wr, take;
      byteMask_t m;
      for (int r = 0; r < 32; r++) x[r] = 0;
      pc = 0;
      for (int step = 0; step < 20000; step++) begin
         ins = instrMem[pc[11:2]];
         if (ins == selfJump) break;
         f3 = ins[14:12];
         r1 = x[ins[19:15]];
         r2 = x[ins[24:20]];
         immI = {{20{ins[31]}}, ins[31:20]};
         immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         immU = {ins[31:12], 12'd0};
         nextPc = pc + 32'd4;
         wr = 1'b1;
         res = 0;
         case (ins[6:0])
            `OPC_LUI: res = immU;
            `OPC_AUIPC: res = pc + immU;
            `OPC_JAL: begin
               res = pc + 32'd4;
               nextPc = pc + immJ;
            end
            `OPC_JALR: begin
               res = pc + 32'd4;
               nextPc = (r1 + immI) & ~32'd1;
            end
            `OPC_BRANCH: begin
               wr = 1'b0;
               case (f3)
                  `F3_BEQ: take = r1 == r2;
                  `F3_BNE: take = r1 != r2;
                  `F3_BLT: take = $signed(r1) < $signed(r2);
                  `F3_BGE: take = $signed(r1) >= $signed(r2);
                  `F3_BLTU: take = r1 < r2;
                  default: take = r1 >= r2;
               endcase
               if (take) nextPc = pc + immB;
            end
            `OPC_LOAD: begin
               addr = r1 + immI;
               w = modelMem[addr[11:2]] >> {addr[1:0], 3'b000};
               case (f3)
                  `F3_LB: res = {{24{w[7]}}, w[7:0]};
                  `F3_LH: res = {{16{w[15]}}, w[15:0]};
                  `F3_LBU: res = {24'd0, w[7:0]};
                  `F3_LHU: res = {16'd0, w[15:0]};
                  default: res = w;
               endcase
            end
            `OPC_STORE: begin
               wr = 1'b0;
               addr = r1 + immS;
               m = (f3 == 3'd0) ? 4'b0001 << addr[1:0] :
                   (f3 == 3'd1) ? 4'b0011 << addr[1:0] : 4'b1111;
               w = r2 << {addr[1:0], 3'b000};
               for (int l = 0; l < 4; l++) begin
                  if (m[l]) modelMem[addr[11:2]][8*l +: 8] = w[8*l +: 8];
               end
               // Only the written lanes carry data
               expAddr.push_back(addr);
               expMask.push_back(m);
               expData.push_back(w & laneBits(m));
            end
            `OPC_OPIMM: res = aluCalc(f3, ins[30] && f3 == 3'd5, r1, immI);
            default: res = aluCalc(f3, ins[30], r1, r2);
         endcase
         if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
         pc = nextPc;
      end
   endfunction

   function automatic word_t laneBits(input byteMask_t m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   // Memory models with one cycle of latency, plus the stall source
   always @(posedge clk) begin
      icRe = icacheRe;
      icAddr = icacheAddr;
      dcRe = dcacheRe;
      dcAddr = dcacheAddr;
      dcWe = dcacheWe;
      dcDin = dcacheDin;
      for (int l = 0; l < 4; l++) begin
         if (dcWe[l]) dataMem[dcAddr[11:2]][8*l +: 8] = dcDin[8*l +: 8];
      end
      #1;
      if (icRe) instruction = instrMem[icAddr[11:2]];
      if (dcRe) dcacheDout = dataMem[dcAddr[11:2]];
      rnd = randWord();
      stall = stallOn && rnd[2:0] == 3'b000;
   end

   // Store checker
   always @(posedge clk) begin
      if (rstN && stall) begin
         assert (dcacheWe == 4'b0000)
            else wrongValue("dcacheWe while stalled", 0, word_t'(dcacheWe));
      end
      if (rstN && dcacheWe != 4'b0000) begin
         if (storeIdx >= expAddr.size()) begin
            failNow("a store arrived after the expected sequence was complete");
         end else begin
            assert (dcacheAddr == expAddr[storeIdx])
               else wrongValue("dcacheAddr", expAddr[storeIdx], dcacheAddr);
            assert (dcacheWe == expMask[storeIdx])
               else wrongValue("dcacheWe", word_t'(expMask[storeIdx]), word_t'(dcacheWe));
            assert ((dcacheDin & laneBits(expMask[storeIdx])) == expData[storeIdx])
               else wrongValue("dcacheDin", expData[storeIdx],
                               dcacheDin & laneBits(expMask[storeIdx]));
            storeIdx++;
         end
      end
   end

   // Outputs while in reset and the first fetch
   initial begin
      int cnt;
      cnt = 0;
      @(posedge clk);
      while (!rstN && cnt < 100) begin
         assert (dcacheWe == 4'b0000) else wrongValue("dcacheWe", 0, word_t'(dcacheWe));
         assert (!dcacheRe) else wrongValue("dcacheRe", 0, word_t'(dcacheRe));
         assert (!icacheRe) else wrongValue("icacheRe", 0, word_t'(icacheRe));
         assert (icacheAddr == `RESET_PC)
            else wrongValue("icacheAddr", word_t'(`RESET_PC), word_t'(icacheAddr));
         @(posedge clk);
         cnt++;
      end
      cnt = 0;
      while (!(rstN && icacheRe) && cnt < 100) begin
         @(posedge clk);
         cnt++;
      end
      if (!(rstN && icacheRe)) begin
         failNow("no instruction fetch started after reset");
      end else begin
         assert (icacheAddr == `RESET_PC)
            else wrongValue("icacheAddr", word_t'(`RESET_PC), word_t'(icacheAddr));
      end
   end

   initial begin
      rstN = 1'b0;
      stall = 1'b0;
      stallOn = 1'b0;
      instruction = `NOP_INSTR;
      dcacheDout = 0;
      storeIdx = 0;
      rngState = 32'h4954_f750;
      selfJump = encJ(0, 0);
      nextSlot = 32'd1024;
      pcW = 0;
      for (int i = 0; i < 1024; i++) begin
         instrMem[i] = `NOP_INSTR;
         dataMem[i] = (i + 1) * 32'h9e37_79b9 ^ (i << 16);
         modelMem[i] = dataMem[i];
      end
      buildProgram();
      runModel();
      repeat (10) @(posedge clk);
      #1;
      rstN = 1'b1;
      stallOn = 1'b1;
      waited = 0;
      while (storeIdx < expAddr.size() && waited < 20000) begin
         @(posedge clk);
         waited++;
      end
      if (storeIdx < expAddr.size()) begin
         failNow("timeout, the expected stores did not all arrive");
      end else begin
         // The core now spins on the self-jump
         repeat (40) @(posedge clk);
         $display("sim passed");
         $finish;
      end
   end

endmodule

/* riscvCore.f */
+incdir+verilog
verilog/riscvPkg.sv
verilog/dataMemIf.sv
verilog/regFile.sv
verilog/alu.sv
verilog/decoder.sv
verilog/hazardUnit.sv
verilog/loadStoreUnit.sv
verilog/riscvPipeline.sv
verilog/riscvCore.sv
sim/riscvCoreTb.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f riscvCore.f \
   --top-module riscvCoreTb -o riscvCoreSim \
   && ./obj_dir/riscvCoreSim | tee /dev/stderr | grep -q "^sim passed$" \
   && echo "simulation result: PASS" \
   || { echo "simulation result: FAIL"; exit 1; }
